// ==== source/pal_types_pkg.sv ====
// Shared palette types. Widths follow the reference chip, with 5-bit channels and a 1024-entry store.
package pal_types_pkg;

    // ====================
    // Video side widths.
    // ====================

    // Colour index from one tile layer.
    typedef logic [7:0] color_index_t;

    // One colour channel, as stored in the palette.
    typedef logic [4:0] channel_t;

    // Palette RAM address, bank in bits 9:8.
    typedef logic [9:0] ram_addr_t;

    typedef logic [1:0] bank_t;    // Bank number.

    // ====================
    // CPU side widths.
    // ====================

    typedef logic [19:0] cpu_addr_t;    // Byte address.
    typedef logic [15:0] cpu_data_t;    // Data bus word.

    // ====================
    // State machines.
    // ====================

    // CPU handshake control.
    typedef enum logic [1:0]
    {
        IDLE,        // Waiting for a request.
        ACCESS,      // RAM access under way.
        ACK_HIGH     // Ack held until req drops.
    } bus_state_t;

    // Channel fetch order. HOLD is the idle phase.
    typedef enum logic [1:0]
    {
        RED,
        GREEN,
        BLUE,
        HOLD
    } fetch_phase_t;

endpackage

// ==== source/pal_map_pkg.sv ====
// CPU address map of the palette. Bit A0 is part of the select code and is not a byte lane.
package pal_map_pkg;

    // ====================
    // Address fields.
    // ====================

    localparam int INDEX_LSB = 1;    // Index field is A[8:1].
    localparam int INDEX_W   = $bits(pal_types_pkg::color_index_t);

    // Select code is {A11, A10, A0}.
    localparam int SEL_BIT_HI  = 11;
    localparam int SEL_BIT_MID = 10;
    localparam int SEL_BIT_LO  = 0;

    // Codes that reach a colour bank. Red answers on two codes.
    localparam logic [2:0] SEL_CODE_RED     = 3'b000;
    localparam logic [2:0] SEL_CODE_RED_ALT = 3'b110;
    localparam logic [2:0] SEL_CODE_GREEN   = 3'b010;
    localparam logic [2:0] SEL_CODE_BLUE    = 3'b100;

    // ====================
    // Banks.
    // ====================

    localparam pal_types_pkg::bank_t BANK_RED   = 2'd0;
    localparam pal_types_pkg::bank_t BANK_GREEN = 2'd1;
    localparam pal_types_pkg::bank_t BANK_BLUE  = 2'd2;
    localparam pal_types_pkg::bank_t BANK_SPARE = 2'd3;    // All other codes.

    // Four banks of 256 entries.
    localparam int PAL_DEPTH = 1024;

endpackage

// ==== source/palette_bus_ctrl.sv ====
// CPU side of the palette. The CPU holds address and data stable while req is high; ack comes 3 cycles after req.
`timescale 1ns/1ps

module palette_bus_ctrl (
    input  logic                     CLK_32M,
    input  logic                     arst_n,
    input  logic                     cpu_req,
    input  logic                     cpu_we,
    input  pal_types_pkg::cpu_addr_t cpu_addr,
    input  pal_types_pkg::cpu_data_t cpu_wdata,
    input  pal_types_pkg::channel_t  ram_rdata,
    output logic                     cpu_ack,
    output pal_types_pkg::cpu_data_t cpu_rdata,
    output logic                     ram_en,
    output logic                     ram_we,
    output pal_types_pkg::ram_addr_t ram_addr,
    output pal_types_pkg::channel_t  ram_wdata
);

    pal_types_pkg::bus_state_t state;
    logic                      req_we;      // Direction of the captured request.
    logic                      issued;      // RAM strobe already sent.
    logic [2:0]                sel_code;    // {A11, A10, A0}.
    pal_types_pkg::bank_t      bank;        // Decoded bank.
    logic                      take_req;    // New request accepted.
    logic                      done;        // Last cycle of ACCESS.

    // ====================
    // Address decode.
    // ====================

    assign sel_code = {cpu_addr[pal_map_pkg::SEL_BIT_HI],
                       cpu_addr[pal_map_pkg::SEL_BIT_MID],
                       cpu_addr[pal_map_pkg::SEL_BIT_LO]};

    always_comb
    begin
        case (sel_code)
            pal_map_pkg::SEL_CODE_RED,
            pal_map_pkg::SEL_CODE_RED_ALT: bank = pal_map_pkg::BANK_RED;
            pal_map_pkg::SEL_CODE_GREEN:   bank = pal_map_pkg::BANK_GREEN;
            pal_map_pkg::SEL_CODE_BLUE:    bank = pal_map_pkg::BANK_BLUE;
            default:                       bank = pal_map_pkg::BANK_SPARE;
        endcase
    end

    // Ack must be low before a new request counts.
    assign take_req = (state == pal_types_pkg::IDLE) && cpu_req && !cpu_ack;

    // RAM strobe sent and dropped, so read data is on ram_rdata.
    assign done = (state == pal_types_pkg::ACCESS) && issued && !ram_en;

    // ====================
    // Control FSM.
    // ====================

    always_ff @(posedge CLK_32M or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state   <= pal_types_pkg::IDLE;
            cpu_ack <= 1'b0;
            ram_en  <= 1'b0;
            ram_we  <= 1'b0;
            req_we  <= 1'b0;
            issued  <= 1'b0;
        end
        else
        begin
            case (state)
                pal_types_pkg::IDLE:
                begin
                    if (take_req)
                    begin
                        req_we <= cpu_we;
                        issued <= 1'b0;
                        state  <= pal_types_pkg::ACCESS;
                    end
                end
                pal_types_pkg::ACCESS:
                begin
                    if (!issued)
                    begin
                        ram_en <= 1'b1;       // One RAM cycle.
                        ram_we <= req_we;
                        issued <= 1'b1;
                    end
                    else if (ram_en)
                    begin
                        ram_en <= 1'b0;       // RAM acts on this edge.
                        ram_we <= 1'b0;
                    end
                    else
                    begin
                        cpu_ack <= 1'b1;      // Data latched alongside.
                        state   <= pal_types_pkg::ACK_HIGH;
                    end
                end
                pal_types_pkg::ACK_HIGH:
                begin
                    if (!cpu_req)
                    begin
                        cpu_ack <= 1'b0;
                        state   <= pal_types_pkg::IDLE;
                    end
                end
                default: state <= pal_types_pkg::IDLE;
            endcase
        end
    end

    // Address, write data and read data.
    always_ff @(posedge CLK_32M)
    begin
        if (take_req)
        begin
            ram_addr  <= {bank, cpu_addr[pal_map_pkg::INDEX_LSB +: pal_map_pkg::INDEX_W]};
            ram_wdata <= cpu_wdata[4:0];    // Only the low 5 bits are stored.
        end
        if (done)
            cpu_rdata <= pal_types_pkg::cpu_data_t'(ram_rdata);    // Zero-extended.
    end

    // ====================
    // Checks.
    // ====================

    // Ack is only raised while the CPU still holds req.
    a_ack_needs_req: assert property (@(posedge CLK_32M) disable iff (!arst_n)
        $rose(cpu_ack) |-> $past(cpu_req));

    // One RAM strobe per access.
    a_ram_en_pulse: assert property (@(posedge CLK_32M) disable iff (!arst_n)
        ram_en |=> !ram_en);

endmodule

// ==== source/palette_ram.sv ====
// Palette store of 1024 x 5 bits in four banks. Both ports are synchronous and the array has no reset.
`timescale 1ns/1ps

module palette_ram (
    input  logic                     CLK_32M,
    input  logic                     ram_en,
    input  logic                     ram_we,
    input  pal_types_pkg::ram_addr_t ram_addr,
    input  pal_types_pkg::channel_t  ram_wdata,
    input  pal_types_pkg::ram_addr_t vid_addr,
    output pal_types_pkg::channel_t  ram_rdata,
    output pal_types_pkg::channel_t  vid_rdata
);

    // ====================
    // Storage.
    // ====================

    // Bank is the top two address bits.
    pal_types_pkg::channel_t mem [pal_map_pkg::PAL_DEPTH];

    // ====================
    // CPU port.
    // ====================

    // Read or write, one per strobe.
    always_ff @(posedge CLK_32M)
    begin
        if (ram_en)
        begin
            if (ram_we)
                mem[ram_addr] <= ram_wdata;
            else
                ram_rdata <= mem[ram_addr];    // Held until next read.
        end
    end

    // ====================
    // Video port.
    // ====================

    // Read every cycle, never stalled by the CPU.
    // Same-address write in the same cycle gives the old entry.
    always_ff @(posedge CLK_32M)
    begin
        vid_rdata <= mem[vid_addr];
    end

endmodule

// ==== source/channel_fetch.sv ====
// Per-pixel channel sequencer. ce_pix must not come while red or green is being addressed; output is 4 cycles late.
`timescale 1ns/1ps

module channel_fetch (
    input  logic                        CLK_32M,
    input  logic                        arst_n,
    input  logic                        ce_pix,
    input  pal_types_pkg::color_index_t layer_a,
    input  pal_types_pkg::color_index_t layer_b,
    input  logic                        layer_sel,
    input  logic                        blank1_n,
    input  logic                        blank2_n,
    input  pal_types_pkg::channel_t     vid_rdata,
    output pal_types_pkg::ram_addr_t    vid_addr,
    output pal_types_pkg::channel_t     red,
    output pal_types_pkg::channel_t     grn,
    output pal_types_pkg::channel_t     blu
);

    pal_types_pkg::fetch_phase_t phase;         // Channel being addressed.
    pal_types_pkg::fetch_phase_t data_phase;    // Channel now on vid_rdata.
    pal_types_pkg::color_index_t idx;           // Latched colour index.
    pal_types_pkg::bank_t        bank;
    logic                        blank_q;       // Blank of the latched pixel.
    logic                        blank_blu;     // Blank travelling with blue.
    pal_types_pkg::channel_t     red_q;
    pal_types_pkg::channel_t     grn_q;

    // ====================
    // Address side.
    // ====================

    always_comb
    begin
        case (phase)
            pal_types_pkg::RED:   bank = pal_map_pkg::BANK_RED;
            pal_types_pkg::GREEN: bank = pal_map_pkg::BANK_GREEN;
            pal_types_pkg::BLUE:  bank = pal_map_pkg::BANK_BLUE;
            default:              bank = pal_map_pkg::BANK_SPARE;    // Idle read.
        endcase
    end

    assign vid_addr = {bank, idx};

    always_ff @(posedge CLK_32M or negedge arst_n)
    begin
        if (!arst_n)
        begin
            phase      <= pal_types_pkg::HOLD;
            data_phase <= pal_types_pkg::HOLD;
            idx        <= '0;
            blank_q    <= 1'b0;
            blank_blu  <= 1'b0;
            red        <= '0;
            grn        <= '0;
            blu        <= '0;
        end
        else
        begin
            data_phase <= phase;    // RAM has one cycle latency.

            if (phase == pal_types_pkg::BLUE)
                blank_blu <= blank_q;    // Frees blank_q for the next pixel.

            if (ce_pix)
            begin
                idx     <= layer_sel ? layer_a : layer_b;
                blank_q <= !(blank1_n && blank2_n);    // Either blank wins.
                phase   <= pal_types_pkg::RED;
            end
            else
            begin
                case (phase)
                    pal_types_pkg::RED:   phase <= pal_types_pkg::GREEN;
                    pal_types_pkg::GREEN: phase <= pal_types_pkg::BLUE;
                    default:              phase <= pal_types_pkg::HOLD;
                endcase
            end

            // ====================
            // Output load.
            // ====================
            if (data_phase == pal_types_pkg::BLUE)
            begin
                red <= blank_blu ? '0 : red_q;    // All three together.
                grn <= blank_blu ? '0 : grn_q;
                blu <= blank_blu ? '0 : vid_rdata;
            end
        end
    end

    // Red and green wait here for blue.
    always_ff @(posedge CLK_32M)
    begin
        case (data_phase)
            pal_types_pkg::RED:   red_q <= vid_rdata;
            pal_types_pkg::GREEN: grn_q <= vid_rdata;
            default: ;
        endcase
    end

    // Pixel pacing must leave room for red and green.
    a_ce_pix_spacing: assert property (@(posedge CLK_32M) disable iff (!arst_n)
        ce_pix |-> !(phase inside {pal_types_pkg::RED, pal_types_pkg::GREEN}));

endmodule

// ==== source/palette_top.sv ====
// Palette subsystem top. Single clock domain; CPU bus is a four-phase req/ack handshake.
`timescale 1ns/1ps

module palette_top (
    input  logic                        CLK_32M,
    input  logic                        arst_n,
    // CPU bus.
    input  logic                        cpu_req,
    input  logic                        cpu_we,
    input  pal_types_pkg::cpu_addr_t    cpu_addr,
    input  pal_types_pkg::cpu_data_t    cpu_wdata,
    output logic                        cpu_ack,
    output pal_types_pkg::cpu_data_t    cpu_rdata,
    // Video side.
    input  logic                        ce_pix,
    input  pal_types_pkg::color_index_t layer_a,
    input  pal_types_pkg::color_index_t layer_b,
    input  logic                        layer_sel,
    input  logic                        blank1_n,
    input  logic                        blank2_n,
    output pal_types_pkg::channel_t     red,
    output pal_types_pkg::channel_t     grn,
    output pal_types_pkg::channel_t     blu
);

    // ====================
    // Internal buses.
    // ====================

    logic                     ram_en;
    logic                     ram_we;
    pal_types_pkg::ram_addr_t ram_addr;
    pal_types_pkg::channel_t  ram_wdata;
    pal_types_pkg::channel_t  ram_rdata;
    pal_types_pkg::ram_addr_t vid_addr;     // Fetch address.
    pal_types_pkg::channel_t  vid_rdata;    // Fetch data.

    // CPU handshake and decode.
    palette_bus_ctrl u_bus_ctrl (
        .CLK_32M   (CLK_32M),
        .arst_n    (arst_n),
        .cpu_req   (cpu_req),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .ram_rdata (ram_rdata),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata)
    );

    // Two-port palette store.
    palette_ram u_ram (
        .CLK_32M   (CLK_32M),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .vid_addr  (vid_addr),
        .ram_rdata (ram_rdata),
        .vid_rdata (vid_rdata)
    );

    // Colour lookup per pixel.
    channel_fetch u_fetch (
        .CLK_32M   (CLK_32M),
        .arst_n    (arst_n),
        .ce_pix    (ce_pix),
        .layer_a   (layer_a),
        .layer_b   (layer_b),
        .layer_sel (layer_sel),
        .blank1_n  (blank1_n),
        .blank2_n  (blank2_n),
        .vid_rdata (vid_rdata),
        .vid_addr  (vid_addr),
        .red       (red),
        .grn       (grn),
        .blu       (blu)
    );

endmodule

// ==== bench/palette_tb.sv ====
// Run from the project root for bench/palette_vectors.txt; ce_pix pulses every 4 cycles.
`timescale 1ns/1ps

module palette_tb;

    localparam int MAX_VEC  = 64;     // Vector storage depth.
    localparam int N_RANDOM = 200;    // Random CPU accesses.

    logic                        CLK_32M;
    logic                        arst_n;
    logic                        cpu_req;
    logic                        cpu_we;
    pal_types_pkg::cpu_addr_t    cpu_addr;
    pal_types_pkg::cpu_data_t    cpu_wdata;
    logic                        cpu_ack;
    pal_types_pkg::cpu_data_t    cpu_rdata;
    logic                        ce_pix;
    pal_types_pkg::color_index_t layer_a;
    pal_types_pkg::color_index_t layer_b;
    logic                        layer_sel;
    logic                        blank1_n;
    logic                        blank2_n;
    pal_types_pkg::channel_t     red;
    pal_types_pkg::channel_t     grn;
    pal_types_pkg::channel_t     blu;

    // Vector table filled from the file.
    logic [7:0]  vec_op [MAX_VEC];
    logic [19:0] vec_f1 [MAX_VEC];
    logic [15:0] vec_f2 [MAX_VEC];
    logic        vec_f3 [MAX_VEC];
    logic [1:0]  vec_f4 [MAX_VEC];
    logic [14:0] vec_f5 [MAX_VEC];
    int          n_vec;
    logic        loaded;

    pal_types_pkg::channel_t shadow [1024];    // Expected palette for the random test.

    int errors;
    int tests_pass;
    int tests_fail;
    int seed;

    // Pixel whose result is still in the pipeline.
    logic        pend_valid;
    logic [14:0] pend_rgb;
    string       pend_name;
    int          pend_base;

    palette_top UUT (
        .CLK_32M   (CLK_32M),
        .arst_n    (arst_n),
        .cpu_req   (cpu_req),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .ce_pix    (ce_pix),
        .layer_a   (layer_a),
        .layer_b   (layer_b),
        .layer_sel (layer_sel),
        .blank1_n  (blank1_n),
        .blank2_n  (blank2_n),
        .red       (red),
        .grn       (grn),
        .blu       (blu)
    );

    always #5 CLK_32M = ~CLK_32M;    // 10 ns period.

    // ====================
    // Helpers.
    // ====================

    task automatic end_test(input string name, input int base);
        if (errors == base)
        begin
            $display("%s: ok", name);
            tests_pass++;
        end
        else
        begin
            $display("%s: %0d error(s)", name, errors - base);
            tests_fail++;
        end
    endtask

    // Bank from the select code {A11, A10, A0}.
    function automatic pal_types_pkg::bank_t bank_of(input logic [2:0] code);
        if (code == 3'b000 || code == 3'b110)
            return 2'd0;
        else if (code == 3'b010)
            return 2'd1;
        else if (code == 3'b100)
            return 2'd2;
        return 2'd3;    // Spare.
    endfunction

    // One four-phase access; called 1 ns after a rising edge.
    task automatic cpu_access(input logic we, input pal_types_pkg::cpu_addr_t addr,
                              input pal_types_pkg::cpu_data_t wdata, input int hold,
                              output pal_types_pkg::cpu_data_t rdata);
        int n;
        n = 0;
        if (cpu_ack !== 1'b0)
        begin
            $display("cpu_ack was still high before a new request");
            errors++;
        end
        cpu_addr  = addr;
        cpu_we    = we;
        cpu_wdata = wdata;
        cpu_req   = 1'b1;
        while (cpu_ack !== 1'b1 && n < 10)
        begin
            @(posedge CLK_32M);
            #1;
            n++;
        end
        if (cpu_ack !== 1'b1)
        begin
            $display("cpu_ack did not rise within 10 cycles of cpu_req");
            errors++;
        end
        else if (n - 1 != 3)
        begin
            $display("cpu_ack rose %0d cycles after cpu_req was sampled, not 3", n - 1);
            errors++;
        end
        rdata = cpu_rdata;
        repeat (hold)
        begin
            @(posedge CLK_32M);
            #1;
            if (cpu_ack !== 1'b1)
            begin
                $display("cpu_ack dropped while cpu_req was still high");
                errors++;
            end
        end
        cpu_req = 1'b0;
        @(posedge CLK_32M);
        #1;
        if (cpu_ack !== 1'b0)
        begin
            $display("cpu_ack did not fall one cycle after cpu_req dropped");
            errors++;
        end
    endtask

    // Compare the outputs with the pixel in flight.
    task automatic check_pending();
        if (pend_valid)
        begin
            if (red !== pend_rgb[14:10])
            begin
                $display("FAILED red expected 0x%h got 0x%h", pend_rgb[14:10], red);
                errors++;
            end
            if (grn !== pend_rgb[9:5])
            begin
                $display("FAILED grn expected 0x%h got 0x%h", pend_rgb[9:5], grn);
                errors++;
            end
            if (blu !== pend_rgb[4:0])
            begin
                $display("FAILED blu expected 0x%h got 0x%h", pend_rgb[4:0], blu);
                errors++;
            end
            if (pend_name != "")
                end_test(pend_name, pend_base);
            pend_valid = 1'b0;
        end
    endtask

    // Pulse ce_pix; the result is checked on the next pulse or flush.
    task automatic pixel(input pal_types_pkg::color_index_t a,
                         input pal_types_pkg::color_index_t b,
                         input logic sel, input logic [1:0] blanks, input logic [14:0] exp_rgb,
                         input string name);
        logic [14:0] held;
        layer_a   = a;
        layer_b   = b;
        layer_sel = sel;
        blank1_n  = blanks[1];
        blank2_n  = blanks[0];
        ce_pix    = 1'b1;
        @(posedge CLK_32M);
        #1;
        ce_pix = 1'b0;
        check_pending();    // Previous pixel loaded on this edge.
        pend_base = errors;
        held      = {red, grn, blu};
        repeat (3) @(posedge CLK_32M);
        #1;
        if ({red, grn, blu} !== held)
        begin
            $display("Pixel outputs changed less than 4 cycles after ce_pix");
            errors++;
        end
        pend_valid = 1'b1;
        pend_rgb   = exp_rgb;
        pend_name  = name;
    endtask

    task automatic flush_pixel();
        if (pend_valid)
        begin
            @(posedge CLK_32M);
            #1;
            check_pending();
        end
    endtask

    // ====================
    // Watchdog.
    // ====================

    initial
    begin
        wait (loaded);
        repeat ((n_vec + N_RANDOM) * 20 + 1000) @(posedge CLK_32M);
        $display("Run timed out before all tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // ====================
    // Main sequence.
    // ====================

    initial
    begin
        int fd;
        int cnt;
        int base;
        int k;
        string line;
        string name;
        logic [7:0] op;
        logic [19:0] f1;
        logic [15:0] f2;
        logic f3;
        logic [1:0] f4;
        logic [14:0] f5;
        pal_types_pkg::cpu_data_t rd;
        logic [31:0] r;
        logic [2:0] code;
        pal_types_pkg::color_index_t idx;
        pal_types_pkg::color_index_t pa;
        pal_types_pkg::color_index_t pb;
        pal_types_pkg::bank_t bank;
        logic [1:0] blanks;

        CLK_32M    = 1'b0;
        arst_n     = 1'b0;
        cpu_req    = 1'b0;
        cpu_we     = 1'b0;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        ce_pix     = 1'b0;
        layer_a    = '0;
        layer_b    = '0;
        layer_sel  = 1'b0;
        blank1_n   = 1'b1;
        blank2_n   = 1'b1;
        errors     = 0;
        tests_pass = 0;
        tests_fail = 0;
        pend_valid = 1'b0;
        pend_rgb   = '0;
        pend_name  = "";
        pend_base  = 0;
        seed       = 32'h7348;
        n_vec      = 0;
        loaded     = 1'b0;

        // Load vectors; comment and blank lines give fewer than 6 fields.
        fd = $fopen("bench/palette_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open bench/palette_vectors.txt");
            errors++;
        end
        else
        begin
            while (!$feof(fd) && n_vec < MAX_VEC)
            begin
                line = "";
                cnt  = $fgets(line, fd);
                cnt  = $sscanf(line, "%c %h %h %h %h %h", op, f1, f2, f3, f4, f5);
                if (cnt == 6 && op != "#")
                begin
                    vec_op[n_vec] = op;
                    vec_f1[n_vec] = f1;
                    vec_f2[n_vec] = f2;
                    vec_f3[n_vec] = f3;
                    vec_f4[n_vec] = f4;
                    vec_f5[n_vec] = f5;
                    n_vec++;
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;

        // Reset for 8 cycles.
        repeat (8) @(posedge CLK_32M);
        #1;
        arst_n = 1'b1;
        @(posedge CLK_32M);
        #1;

        // ====================
        // Reset state.
        // ====================
        base = errors;
        if (cpu_ack !== 1'b0)
        begin
            $display("FAILED cpu_ack expected 0x0 got 0x%h", cpu_ack);
            errors++;
        end
        if (red !== 5'h0)
        begin
            $display("FAILED red expected 0x00 got 0x%h", red);
            errors++;
        end
        if (grn !== 5'h0)
        begin
            $display("FAILED grn expected 0x00 got 0x%h", grn);
            errors++;
        end
        if (blu !== 5'h0)
        begin
            $display("FAILED blu expected 0x00 got 0x%h", blu);
            errors++;
        end
        end_test("reset state", base);

        // ====================
        // Vector file.
        // ====================
        for (k = 0; k < n_vec; k++)
        begin
            name = $sformatf("vector %0d %c", k, vec_op[k]);
            if (vec_op[k] == "P")
            begin
                pixel(vec_f1[k][7:0], vec_f2[k][7:0], vec_f3[k], vec_f4[k], vec_f5[k], name);
            end
            else
            begin
                flush_pixel();
                base = errors;
                if (vec_op[k] == "W")
                    cpu_access(1'b1, vec_f1[k], vec_f2[k], 0, rd);
                else if (vec_op[k] == "R")
                begin
                    cpu_access(1'b0, vec_f1[k], 16'h0, 0, rd);
                    if (rd !== vec_f2[k])
                    begin
                        $display("FAILED cpu_rdata expected 0x%h got 0x%h", vec_f2[k], rd);
                        errors++;
                    end
                end
                else
                begin
                    $display("Unknown opcode in vector %0d", k);
                    errors++;
                end
                end_test(name, base);
            end
        end
        flush_pixel();

        // Ack must hold while req stays high.
        base = errors;
        cpu_access(1'b0, 20'h00024, 16'h0, 5, rd);
        cpu_access(1'b0, 20'h00024, 16'h0, 0, rd);    // Back-to-back after ack low.
        end_test("handshake hold and release", base);

        // ====================
        // Random traffic.
        // ====================
        base = errors;
        // Prime indices 0x40..0x4f in all four banks.
        for (k = 0; k < 64; k++)
        begin
            r    = $random(seed);
            idx  = {4'h4, k[3:0]};
            code = (k[5:4] == 2'd0) ? 3'b000 : (k[5:4] == 2'd1) ? 3'b010 :
                   (k[5:4] == 2'd2) ? 3'b100 : 3'b001;
            shadow[{bank_of(code), idx}] = r[4:0];
            cpu_access(1'b1, {8'h00, code[2:1], 1'b0, idx, code[0]}, r[15:0], 0, rd);
        end
        for (k = 0; k < N_RANDOM; k++)
        begin
            r    = $random(seed);
            code = r[2:0];
            idx  = {4'h4, r[6:3]};
            bank = bank_of(code);
            if (r[7])
            begin
                shadow[{bank, idx}] = r[20:16];
                cpu_access(1'b1, {r[31:24], code[2:1], r[8], idx, code[0]}, r[31:16], 0, rd);
            end
            else
            begin
                cpu_access(1'b0, {r[31:24], code[2:1], r[8], idx, code[0]}, 16'h0, 0, rd);
                if (rd !== {11'h0, shadow[{bank, idx}]})
                begin
                    $display("FAILED cpu_rdata expected 0x%h got 0x%h",
                             {11'h0, shadow[{bank, idx}]}, rd);
                    errors++;
                end
            end
            if (k % 4 == 3)
            begin
                r      = $random(seed);
                pa     = {4'h4, r[3:0]};
                pb     = {4'h4, r[7:4]};
                blanks = (r[10:8] == 3'd0) ? r[12:11] : 2'b11;    // Mostly visible.
                idx    = r[13] ? pa : pb;
                pixel(pa, pb, r[13], blanks,
                      (blanks != 2'b11) ? 15'h0 :
                      {shadow[{2'd0, idx}], shadow[{2'd1, idx}], shadow[{2'd2, idx}]}, "");
            end
        end
        flush_pixel();
        end_test("random traffic", base);

        $display("Tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail, errors);
        if (errors == 0 && tests_fail == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== bench/palette_vectors.txt ====
# Columns (hex): op f1 f2 f3 f4 f5. W: addr data. R: addr expected rdata.
# P: layer_a layer_b layer_sel {blank1_n,blank2_n} expected {red,grn,blu} as 5:5:5.
# Index 0x12 in red, green and blue banks.
W 00024 0011 0 0 0000
W 00424 0f0a 0 0 0000
W 00824 0007 0 0 0000
R 00024 0011 0 0 0000
R 00c24 0011 0 0 0000
R 00424 000a 0 0 0000
R 00824 0007 0 0 0000
# Spare bank through codes 001, 011, 101 and 111.
W 00025 001f 0 0 0000
R 00024 0011 0 0 0000
R 00424 000a 0 0 0000
R 00824 0007 0 0 0000
R 00425 001f 0 0 0000
R 00825 001f 0 0 0000
R 00c25 001f 0 0 0000
W 00c25 0009 0 0 0000
R 00025 0009 0 0 0000
R 00024 0011 0 0 0000
# Red through the alternate code, only 5 bits stored.
W 00c24 fff3 0 0 0000
R 00024 0013 0 0 0000
R f0024 0013 0 0 0000
R 00224 0013 0 0 0000
# Index 0x34.
W 00068 0005 0 0 0000
W 00468 003c 0 0 0000
W 00868 0002 0 0 0000
R 00068 0005 0 0 0000
R 00468 001c 0 0 0000
R 00868 0002 0 0 0000
# Pixels: layer select, back to back.
P 00012 0034 1 3 4d47
P 00012 0034 0 3 1782
P 00034 0012 1 3 1782
P 00034 0012 0 3 4d47
# Blanking, then visible again.
P 00012 0034 1 2 0000
P 00012 0034 1 1 0000
P 00012 0034 1 0 0000
P 00012 0034 1 3 4d47
P 00012 0034 0 2 0000
P 00012 0034 0 3 1782

// ==== build.f ====
source/pal_types_pkg.sv
source/pal_map_pkg.sv
source/palette_bus_ctrl.sv
source/palette_ram.sv
source/channel_fetch.sv
source/palette_top.sv
bench/palette_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = palette_tb
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log

SHELL := /bin/bash

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	set -o pipefail; ./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
